/* traffic_pkg.sv */
package traffic_pkg;

   ////////////////////////////////////////////////////////////
   // widths and divider ratios
   ////////////////////////////////////////////////////////////

   localparam int timer_w    = 6;         // phase timer, longest phase is 60 ticks
   localparam int tick_cnt_w = 24;        // clk divider

   localparam int unsigned tick_slow_count = 13_350_000; // normal speed
   localparam int unsigned tick_fast_count = 1_350_000;  // debug speed

   typedef logic [timer_w-1:0]    timer_t;
   typedef logic [tick_cnt_w-1:0] tick_cnt_t;

   ////////////////////////////////////////////////////////////
   // phases of the signal cycle
   ////////////////////////////////////////////////////////////

   typedef enum logic [3:0] {
      ew_green,      // east-west through traffic
      ew_walk,       // ew green plus walk lamps
      ew_flash,      // ew green, dont walk flashing
      ew_clear,      // ew green, crossing clearing
      ew_amber,
      all_red_a,     // ew to ns changeover
      sb_left,       // southbound protected left
      ns_walk,
      ns_flash,
      ns_clear,
      ns_green,
      ns_amber,
      all_red_b,     // ns to ew changeover
      phase_spare    // never entered
   } phase_e;

   // phase length in ticks
   function automatic timer_t phase_duration(input phase_e ph);
      case (ph)
         ew_green:  return timer_t'(60);
         ew_walk:   return timer_t'(10);
         ew_flash:  return timer_t'(20);
         ew_clear:  return timer_t'(30);
         ew_amber:  return timer_t'(6);
         all_red_a: return timer_t'(2);
         sb_left:   return timer_t'(20);
         ns_walk:   return timer_t'(10);
         ns_flash:  return timer_t'(20);
         ns_clear:  return timer_t'(30);
         ns_green:  return timer_t'(60);
         ns_amber:  return timer_t'(6);
         all_red_b: return timer_t'(2);
         default:   return '0;            // spare has no length
      endcase
   endfunction

   ////////////////////////////////////////////////////////////
   // requests and lamps
   ////////////////////////////////////////////////////////////

   // synchronized key levels, 1 = requested
   typedef struct packed {
      logic left_turn;
      logic walk_ns;
      logic walk_ew;
   } requests_t;

   // one approach, all active low
   typedef struct packed {
      logic red;
      logic amber;
      logic green;
      logic walk;
      logic dont_walk;
   } approach_lamps_t;

   typedef struct packed {
      approach_lamps_t north;
      approach_lamps_t south;
      approach_lamps_t east;
      approach_lamps_t west;
      logic            sb_left_arrow; // active low
   } signal_heads_t;

endpackage

/* tick_gen.sv */
`timescale 1ns/1ps

module tick_gen #(
   parameter int unsigned slow_count = traffic_pkg::tick_slow_count,
   parameter int unsigned fast_count = traffic_pkg::tick_fast_count
) (
   input  logic clk,
   input  logic reset,
   input  logic debug,   // 1 = fast ratio
   output logic tick,    // one clk wide
   output logic flash    // toggles every tick
);

   traffic_pkg::tick_cnt_t cnt;
   traffic_pkg::tick_cnt_t reload;

   // count minus one, so the tick period is exactly count cycles
   assign reload = debug ? traffic_pkg::tick_cnt_t'(fast_count - 1)
                         : traffic_pkg::tick_cnt_t'(slow_count - 1);

   assign tick = (cnt == '0);             // strobe on terminal count

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         cnt <= reload;                   // first tick one full period after reset
      end else if (tick) begin
         cnt <= reload;
      end else begin
         cnt <= cnt - 1'b1;
      end
   end

   // flash level drives the flashing dont walk
   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         flash <= 1'b0;
      end else if (tick) begin
         flash <= ~flash;
      end
   end

   // reload keeps the strobe a single cycle
   a_tick_single: assert property (@(posedge clk) disable iff (!reset)
      tick |=> !tick);

endmodule

/* phase_timer.sv */
`timescale 1ns/1ps

module phase_timer (
   input  logic                clk,
   input  logic                reset,
   input  logic                tick,
   input  traffic_pkg::phase_e next_phase,
   output logic                phase_done
);

   traffic_pkg::timer_t count;   // ticks left in the current phase

   ////////////////////////////////////////////////////////////
   // phase end detect
   ////////////////////////////////////////////////////////////

   // last tick of the phase, sequencer advances on this edge
   assign phase_done = tick && (count == traffic_pkg::timer_t'(1));

   ////////////////////////////////////////////////////////////
   // down counter
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         count <= traffic_pkg::phase_duration(traffic_pkg::ew_green);
      end else if (phase_done) begin
         // load the phase that is being entered
         count <= traffic_pkg::phase_duration(next_phase);
      end else if (tick) begin
         count <= count - 1'b1;           // one step per tick, 1 is caught by phase_done
      end
   end

   // a zero here means the sequencer handed over the spare phase
   a_count_nonzero: assert property (@(posedge clk) disable iff (!reset)
      count != '0);

endmodule

/* phase_sequencer.sv */
`timescale 1ns/1ps

module phase_sequencer (
   input  logic                clk,
   input  logic                reset,
   input  logic                left_turn_key,  // active low
   input  logic                walk_ns_key,    // active low
   input  logic                walk_ew_key,    // active low
   input  logic                phase_done,
   output traffic_pkg::phase_e phase,
   output traffic_pkg::phase_e next_phase
);

   traffic_pkg::requests_t req_meta;   // first sync stage
   traffic_pkg::requests_t req;        // synchronized, 1 = requested

   ////////////////////////////////////////////////////////////
   // key synchronizers
   ////////////////////////////////////////////////////////////

   // keys are inverted on the way in so the struct holds active high
   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         req_meta <= '0;
         req      <= '0;
      end else begin
         req_meta.left_turn <= ~left_turn_key;
         req_meta.walk_ns   <= ~walk_ns_key;
         req_meta.walk_ew   <= ~walk_ew_key;
         req                <= req_meta;
      end
   end

   ////////////////////////////////////////////////////////////
   // next phase selection
   ////////////////////////////////////////////////////////////

   // requests are plain levels sampled at phase end
   always_comb begin
      case (phase)
         traffic_pkg::ew_green:  next_phase = traffic_pkg::ew_amber;
         traffic_pkg::ew_walk:   next_phase = traffic_pkg::ew_flash;
         traffic_pkg::ew_flash:  next_phase = traffic_pkg::ew_clear;
         traffic_pkg::ew_clear:  next_phase = traffic_pkg::ew_amber;
         traffic_pkg::ew_amber:  next_phase = traffic_pkg::all_red_a;
         traffic_pkg::all_red_a: begin
            if (req.left_turn) begin
               next_phase = traffic_pkg::sb_left;   // protected left first
            end else if (req.walk_ns) begin
               next_phase = traffic_pkg::ns_walk;
            end else begin
               next_phase = traffic_pkg::ns_green;
            end
         end
         traffic_pkg::sb_left: begin
            next_phase = req.walk_ns ? traffic_pkg::ns_walk : traffic_pkg::ns_green;
         end
         traffic_pkg::ns_walk:   next_phase = traffic_pkg::ns_flash;
         traffic_pkg::ns_flash:  next_phase = traffic_pkg::ns_clear;
         traffic_pkg::ns_clear:  next_phase = traffic_pkg::ns_amber;
         traffic_pkg::ns_green:  next_phase = traffic_pkg::ns_amber;
         traffic_pkg::ns_amber:  next_phase = traffic_pkg::all_red_b;
         traffic_pkg::all_red_b: begin
            next_phase = req.walk_ew ? traffic_pkg::ew_walk : traffic_pkg::ew_green;
         end
         default:                next_phase = traffic_pkg::ew_green; // recover from spare
      endcase
   end

   ////////////////////////////////////////////////////////////
   // phase register
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         phase <= traffic_pkg::ew_green;
      end else if (phase_done) begin
         phase <= next_phase;             // advance on last tick
      end
   end

   // phase only moves when the timer runs out
   a_phase_hold: assert property (@(posedge clk) disable iff (!reset)
      !phase_done |=> $stable(phase));

   a_no_spare: assert property (@(posedge clk) disable iff (!reset)
      phase != traffic_pkg::phase_spare);

endmodule

/* lamp_decoder.sv */
`timescale 1ns/1ps

module lamp_decoder (
   input  traffic_pkg::phase_e        phase,
   input  logic                       flash,
   output traffic_pkg::signal_heads_t heads
);

   logic ew_go, ew_amb, ew_walk_ph, ew_flash_ph;   // east-west axis
   logic ns_go, ns_amb, ns_walk_ph, ns_flash_ph;   // north-south axis
   logic left_ph;

   // lamps of one approach, 0 = lit
   function automatic traffic_pkg::approach_lamps_t axis_lamps(
      input logic go,
      input logic amb,
      input logic walk_ph,
      input logic flash_ph,
      input logic flash_lvl
   );
      traffic_pkg::approach_lamps_t l;
      l.green = ~go;
      l.amber = ~amb;
      l.red   = go | amb;                 // red whenever nothing else shows
      l.walk  = ~walk_ph;
      if (walk_ph) begin
         l.dont_walk = 1'b1;              // dark while walking
      end else if (flash_ph) begin
         l.dont_walk = ~flash_lvl;        // lit on the high half of flash
      end else begin
         l.dont_walk = 1'b0;              // steady
      end
      return l;
   endfunction

   ////////////////////////////////////////////////////////////
   // phase groups
   ////////////////////////////////////////////////////////////

   assign ew_go = phase inside {traffic_pkg::ew_green, traffic_pkg::ew_walk,
                                traffic_pkg::ew_flash, traffic_pkg::ew_clear};
   assign ns_go = phase inside {traffic_pkg::ns_walk, traffic_pkg::ns_flash,
                                traffic_pkg::ns_clear, traffic_pkg::ns_green};

   assign ew_amb      = (phase == traffic_pkg::ew_amber);
   assign ns_amb      = (phase == traffic_pkg::ns_amber);
   assign ew_walk_ph  = (phase == traffic_pkg::ew_walk);
   assign ns_walk_ph  = (phase == traffic_pkg::ns_walk);
   assign ew_flash_ph = (phase == traffic_pkg::ew_flash);
   assign ns_flash_ph = (phase == traffic_pkg::ns_flash);
   assign left_ph     = (phase == traffic_pkg::sb_left);

   ////////////////////////////////////////////////////////////
   // signal heads
   ////////////////////////////////////////////////////////////

   always_comb begin
      heads.east  = axis_lamps(ew_go, ew_amb, ew_walk_ph, ew_flash_ph, flash);
      heads.west  = axis_lamps(ew_go, ew_amb, ew_walk_ph, ew_flash_ph, flash);
      heads.north = axis_lamps(ns_go, ns_amb, ns_walk_ph, ns_flash_ph, flash);
      // south shows amber beside the arrow during the protected left
      heads.south = axis_lamps(ns_go, ns_amb | left_ph, ns_walk_ph, ns_flash_ph, flash);
      heads.sb_left_arrow = ~left_ph;
   end

endmodule

/* traffic_ctrl_top.sv */
`timescale 1ns/1ps

module traffic_ctrl_top #(
   parameter int unsigned slow_count = traffic_pkg::tick_slow_count,
   parameter int unsigned fast_count = traffic_pkg::tick_fast_count
) (
   input  logic                       clk,
   input  logic                       reset,          // active low
   input  logic                       debug,          // fast tick
   input  logic                       left_turn_key,  // keys active low
   input  logic                       walk_ns_key,
   input  logic                       walk_ew_key,
   output traffic_pkg::signal_heads_t heads
);

   logic                tick;
   logic                flash;
   logic                phase_done;
   traffic_pkg::phase_e phase;
   traffic_pkg::phase_e next_phase;

   tick_gen #(
      .slow_count (slow_count),
      .fast_count (fast_count)
   ) tick_gen_i (
      .clk   (clk),
      .reset (reset),
      .debug (debug),
      .tick  (tick),
      .flash (flash)
   );

   phase_timer phase_timer_i (
      .clk        (clk),
      .reset      (reset),
      .tick       (tick),
      .next_phase (next_phase),
      .phase_done (phase_done)
   );

   phase_sequencer phase_sequencer_i (
      .clk           (clk),
      .reset         (reset),
      .left_turn_key (left_turn_key),
      .walk_ns_key   (walk_ns_key),
      .walk_ew_key   (walk_ew_key),
      .phase_done    (phase_done),
      .phase         (phase),
      .next_phase    (next_phase)
   );

   lamp_decoder lamp_decoder_i (
      .phase (phase),
      .flash (flash),
      .heads (heads)
   );

endmodule

/* traffic_tb.sv */
`timescale 1ns/1ps

module traffic_tb;

   localparam int unsigned slow_n  = 8;            // clk cycles per tick, normal
   localparam int unsigned fast_n  = 3;            // clk cycles per tick, debug
   localparam int          timeout = 4 * 60 * slow_n;

   logic clk, reset, debug;
   logic left_turn_key, walk_ns_key, walk_ew_key;  // active low
   traffic_pkg::signal_heads_t heads;

   traffic_pkg::signal_heads_t exp_heads;          // pattern the next change must show
   traffic_pkg::signal_heads_t last_heads;         // compare copy of heads
   traffic_pkg::signal_heads_t shown;              // model copy of heads
   traffic_pkg::phase_e        cur;                // model phase
   logic                       flash_m;            // model flash level
   int exp_gap, since, changes, seen, pending, period, seed;
   bit checking;

   traffic_ctrl_top #(
      .slow_count (slow_n),
      .fast_count (fast_n)
   ) traffic_ctrl_top_i (
      .clk           (clk),
      .reset         (reset),
      .debug         (debug),
      .left_turn_key (left_turn_key),
      .walk_ns_key   (walk_ns_key),
      .walk_ew_key   (walk_ew_key),
      .heads         (heads)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;                      // 40 ns period
   end

   ////////////////////////////////////////////////////////////
   // reference model
   ////////////////////////////////////////////////////////////

   function automatic int phase_ticks(input traffic_pkg::phase_e ph);
      case (ph)
         traffic_pkg::ew_green, traffic_pkg::ns_green: return 60;
         traffic_pkg::ew_walk, traffic_pkg::ns_walk:   return 10;
         traffic_pkg::ew_clear, traffic_pkg::ns_clear: return 30;
         traffic_pkg::ew_amber, traffic_pkg::ns_amber: return 6;
         traffic_pkg::ew_flash, traffic_pkg::ns_flash,
         traffic_pkg::sb_left:                         return 20;
         default:                                      return 2;  // all red
      endcase
   endfunction

   // expected lamps, 0 = lit
   function automatic traffic_pkg::signal_heads_t lamp_pattern(input traffic_pkg::phase_e ph,
                                                               input logic fl);
      traffic_pkg::signal_heads_t h;
      h = '1;                                      // start all dark
      case (ph)
         traffic_pkg::ew_green, traffic_pkg::ew_walk, traffic_pkg::ew_flash,
         traffic_pkg::ew_clear: begin
            h.east.green = 1'b0;
            h.west.green = 1'b0;
         end
         traffic_pkg::ew_amber: begin
            h.east.amber = 1'b0;
            h.west.amber = 1'b0;
         end
         default: begin
            h.east.red = 1'b0;
            h.west.red = 1'b0;
         end
      endcase
      case (ph)
         traffic_pkg::ns_walk, traffic_pkg::ns_flash, traffic_pkg::ns_clear,
         traffic_pkg::ns_green: begin
            h.north.green = 1'b0;
            h.south.green = 1'b0;
         end
         traffic_pkg::ns_amber: begin
            h.north.amber = 1'b0;
            h.south.amber = 1'b0;
         end
         traffic_pkg::sb_left: begin
            h.north.red     = 1'b0;                // north held, south turns
            h.south.amber   = 1'b0;
            h.sb_left_arrow = 1'b0;
         end
         default: begin
            h.north.red = 1'b0;
            h.south.red = 1'b0;
         end
      endcase
      h.east.walk       = (ph != traffic_pkg::ew_walk);
      h.west.walk       = (ph != traffic_pkg::ew_walk);
      h.north.walk      = (ph != traffic_pkg::ns_walk);
      h.south.walk      = (ph != traffic_pkg::ns_walk);
      // dark while walking, follows flash in the flash phase, else steady
      h.east.dont_walk  = (ph == traffic_pkg::ew_walk) || (ph == traffic_pkg::ew_flash && !fl);
      h.west.dont_walk  = h.east.dont_walk;
      h.north.dont_walk = (ph == traffic_pkg::ns_walk) || (ph == traffic_pkg::ns_flash && !fl);
      h.south.dont_walk = h.north.dont_walk;
      return h;
   endfunction

   function automatic void predict_next(input traffic_pkg::phase_e cur_ph,
                                        input traffic_pkg::requests_t rq,
                                        input logic fl,
                                        output traffic_pkg::phase_e nxt,
                                        output traffic_pkg::signal_heads_t hd);
      case (cur_ph)
         traffic_pkg::ew_green:  nxt = traffic_pkg::ew_amber;
         traffic_pkg::ew_walk:   nxt = traffic_pkg::ew_flash;
         traffic_pkg::ew_flash:  nxt = traffic_pkg::ew_clear;
         traffic_pkg::ew_clear:  nxt = traffic_pkg::ew_amber;
         traffic_pkg::ew_amber:  nxt = traffic_pkg::all_red_a;
         traffic_pkg::all_red_a: nxt = rq.left_turn ? traffic_pkg::sb_left :
                                       rq.walk_ns ? traffic_pkg::ns_walk : traffic_pkg::ns_green;
         traffic_pkg::sb_left:   nxt = rq.walk_ns ? traffic_pkg::ns_walk : traffic_pkg::ns_green;
         traffic_pkg::ns_walk:   nxt = traffic_pkg::ns_flash;
         traffic_pkg::ns_flash:  nxt = traffic_pkg::ns_clear;
         traffic_pkg::ns_clear:  nxt = traffic_pkg::ns_amber;
         traffic_pkg::ns_green:  nxt = traffic_pkg::ns_amber;
         traffic_pkg::ns_amber:  nxt = traffic_pkg::all_red_b;
         default:                nxt = rq.walk_ew ? traffic_pkg::ew_walk : traffic_pkg::ew_green;
      endcase
      hd = lamp_pattern(nxt, fl);
   endfunction

   task automatic stop_on_error();
      $display("SOME TESTS FAILED");
      $fatal(1, "simulation stopped at the first error");
   endtask

   ////////////////////////////////////////////////////////////
   // compare process, heads sampled on the falling edge
   ////////////////////////////////////////////////////////////

   always @(negedge clk) begin : compare_heads
      if (!checking) begin
         since      = 0;                           // restart the interval at reset release
         last_heads = heads;
      end else begin
         since++;
         if (heads !== last_heads) begin
            assert (heads === exp_heads) else begin
               $display("Mismatch heads: got %h expected %h", heads, exp_heads);
               stop_on_error();
            end
            assert (since == exp_gap) else begin
               $display("Mismatch heads change interval: got %h expected %h", since, exp_gap);
               stop_on_error();
            end
            last_heads = heads;
            since      = 0;
            changes++;
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // stimulus
   ////////////////////////////////////////////////////////////

   task automatic apply_reset(input logic dbg);
      @(posedge clk);
      checking = 1'b0;
      @(negedge clk);
      reset = 1'b0;
      debug = dbg;                                 // ratio is picked up by the reset load
      repeat (8) @(negedge clk);
      reset = 1'b1;
      assert (heads === lamp_pattern(traffic_pkg::ew_green, 1'b0)) else begin
         $display("Mismatch heads: got %h expected %h", heads,
                  lamp_pattern(traffic_pkg::ew_green, 1'b0));
         stop_on_error();
      end
      cur     = traffic_pkg::ew_green;
      flash_m = 1'b0;
      pending = 0;
      shown   = heads;
      period  = dbg ? fast_n : slow_n;
      @(posedge clk);
      seen     = changes;
      checking = 1'b1;
   endtask

   // hand the next change to the compare process and wait for it
   task automatic expect_change(input traffic_pkg::signal_heads_t hd, input int gap);
      int n;
      assert (changes == seen) else begin
         $display("heads changed at a time when no change was expected");
         stop_on_error();
      end
      exp_heads = hd;
      exp_gap   = gap;
      n = 0;
      while (changes == seen && n < timeout) begin
         @(posedge clk);
         n++;
      end
      assert (changes != seen) else begin
         $display("heads did not change within %0d cycles", timeout);
         stop_on_error();
      end
      seen++;
   endtask

   // one phase, tick by tick, with keys held from its start through its end
   task automatic run_phase(input traffic_pkg::requests_t rq);
      traffic_pkg::phase_e        nxt;
      traffic_pkg::signal_heads_t nh;
      int t;
      @(negedge clk);
      left_turn_key = ~rq.left_turn;
      walk_ns_key   = ~rq.walk_ns;
      walk_ew_key   = ~rq.walk_ew;
      @(posedge clk);
      for (t = 1; t <= phase_ticks(cur); t++) begin
         flash_m = ~flash_m;                       // flash toggles on every tick
         pending++;
         if (t == phase_ticks(cur)) begin
            predict_next(cur, rq, flash_m, nxt, nh);
         end else begin
            nh = lamp_pattern(cur, flash_m);
         end
         // flash to clear shows no change, so the interval spans both phases
         if (nh !== shown) begin
            expect_change(nh, pending * period);
            shown   = nh;
            pending = 0;
         end
      end
      cur = nxt;
   endtask

   initial begin : main_seq
      traffic_pkg::requests_t rq;
      int k;
      int r;
      seed          = 32'ha8aa;
      reset         = 1'b0;
      debug         = 1'b0;
      left_turn_key = 1'b1;
      walk_ns_key   = 1'b1;
      walk_ew_key   = 1'b1;
      checking      = 1'b0;
      changes       = 0;
      seen          = 0;
      exp_heads     = '1;
      exp_gap       = 0;
      apply_reset(1'b0);
      for (k = 0; k < 13; k++) run_phase(3'b111);  // every request held, left first
      for (k = 0; k < 4; k++) run_phase(3'b000);   // straight through to ns_green
      apply_reset(1'b1);                           // debug speed from here on
      for (k = 0; k < 50; k++) begin
         r  = $random(seed);
         rq = traffic_pkg::requests_t'(r[2:0]);
         run_phase(rq);
      end
      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

/* build.f */
traffic_pkg.sv
tick_gen.sv
phase_timer.sv
phase_sequencer.sv
lamp_decoder.sv
traffic_ctrl_top.sv
traffic_tb.sv

/* Bender.yml */
package:
  name: traffic_ctrl

sources:
  - traffic_pkg.sv
  - tick_gen.sv
  - phase_timer.sv
  - phase_sequencer.sv
  - lamp_decoder.sv
  - traffic_ctrl_top.sv
  - target: test
    files:
      - traffic_tb.sv
